// File: verilog.f
src/line_bus_pkg.sv
src/req_fifo.sv
src/line_serdes.sv
src/burst_sram.sv
src/line_mem_subsys.sv
testbench/tb_line_model.sv
testbench/tb_line_mem.sv

// File: Makefile
TOP = tb_line_mem

.PHONY: all run lint clean

all: run

run:
	verilator --binary --timing -Wno-fatal -f verilog.f --top-module $(TOP) -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee sim.log
	grep -q "Test passed" sim.log

lint:
	verilator --lint-only --timing -Wall -f verilog.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

// File: testbench/tb_line_mem.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Line memory testbench
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module tb_line_mem;

    localparam int DEPTH   = tb_line_model::DEPTH;
    localparam int N_REQ   = 240;               // Requests over all tests
    localparam int MAX_CYC = 40 * (N_REQ + 1);  // One extra slot covers reset

    logic                      i_clk = 1'b0;
    logic                      i_nrst;
    logic                      i_ar_valid;
    line_bus_pkg::line_req_t   i_ar;
    logic                      o_ar_ready;
    logic                      i_aw_valid;
    line_bus_pkg::line_wreq_t  i_aw;
    logic                      o_aw_ready;
    logic                      o_r_valid;
    line_bus_pkg::line_rsp_t   o_r;
    logic                      i_r_ready;
    logic                      o_b_valid;
    line_bus_pkg::line_bresp_t o_b;
    logic                      i_b_ready;

    int cycles    = 0;
    int checks    = 0;
    int errors    = 0;
    int n_req     = 0;
    int n_rsp     = 0;
    int ready_pct = 50;                         // Chance of ready, in percent
    int t_checks;
    int t_errors;

    line_mem_subsys #(
        .LINE_W(line_bus_pkg::LINE_W), .BUS_W(line_bus_pkg::BUS_W),
        .SRAM_DEPTH(DEPTH), .FIFO_DEPTH(2)
    ) dut (.*);

    always #2 i_clk = ~i_clk;

    always @(posedge i_clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYC) begin
            $display("run stopped after %0d cycles without finishing", cycles);
            $display("Test failed");
            $finish;
        end
    end

    // Every response that transfers on the line side
    always @(posedge i_clk) begin
        n_rsp <= n_rsp + int'(o_r_valid && i_r_ready) + int'(o_b_valid && i_b_ready);
    end

    task automatic check_val(input string name, input logic [255:0] got,
                             input logic [255:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch %s: got %h expected %h", name, got, exp);
        end
    endtask

    function automatic logic coin();
        return ($urandom % 100) < ready_pct;
    endfunction

    function automatic logic [255:0] rand_line();
        logic [255:0] v;
        for (int i = 0; i < 8; i++) begin
            v[i*32 +: 32] = $urandom;
        end
        return v;
    endfunction

    // Word index aligned to the burst, below limit
    function automatic int pick_word(input logic [2:0] size, input int limit);
        int n;
        n = tb_line_model::beats_of(size);
        return int'($urandom % (limit / n)) * n;
    endfunction

    task automatic run_req(input bit wr, input int word, input logic [2:0] size,
                           input logic [31:0] strb);
        line_bus_pkg::line_req_t  req;
        line_bus_pkg::line_wreq_t wreq;
        line_bus_pkg::line_rsp_t  exp_r;
        logic [1:0]               exp_b;
        bit                       done;
        req   = '{addr: 32'(word) << 3, size: size, id: 4'($urandom)};
        wreq  = '{req: req, data: rand_line(), strb: strb};
        exp_r = tb_line_model::expect_read(req);
        exp_b = tb_line_model::expect_bresp(req);
        if (wr) tb_line_model::apply_write(wreq);
        @(negedge i_clk);
        i_ar_valid = !wr;
        i_aw_valid = wr;
        i_ar       = req;
        i_aw       = wreq;
        while (!(wr ? o_aw_ready : o_ar_ready)) @(negedge i_clk);
        n_req++;
        @(negedge i_clk);
        i_ar_valid = 1'b0;
        i_aw_valid = 1'b0;
        done       = 1'b0;
        while (!done) begin
            i_r_ready = coin();
            i_b_ready = coin();
            if (wr ? o_r_valid : o_b_valid) begin
                errors++;
                $display("unexpected %s response while waiting for a %s",
                         wr ? "read" : "write", wr ? "write" : "read");
            end
            if (wr && o_b_valid && i_b_ready) begin
                done = 1'b1;
                check_val("o_b.resp", o_b.resp, exp_b);
                check_val("o_b.id", o_b.id, req.id);
            end else if (!wr && o_r_valid && i_r_ready) begin
                done = 1'b1;
                check_val("o_r.data", o_r.data, exp_r.data);
                check_val("o_r.resp", o_r.resp, exp_r.resp);
                check_val("o_r.id", o_r.id, exp_r.id);
            end
            @(negedge i_clk);
        end
    endtask

    task automatic begin_test();
        t_checks = checks;
        t_errors = errors;
    endtask

    task automatic end_test(input string name);
        $display("test %-12s checks %0d errors %0d", name, checks - t_checks, errors - t_errors);
    endtask

    initial begin
        int         word;
        logic [2:0] size;
        void'($urandom(32'ha77b_b2bd));
        i_nrst     = 1'b0;
        i_ar_valid = 1'b0;
        i_ar       = '0;
        i_aw_valid = 1'b0;
        i_aw       = '0;
        i_r_ready  = 1'b0;
        i_b_ready  = 1'b0;
        repeat (10) @(posedge i_clk);
        @(negedge i_clk);
        i_nrst = 1'b1;

        begin_test();
        @(negedge i_clk);
        check_val("o_r_valid", o_r_valid, 1'b0);
        check_val("o_b_valid", o_b_valid, 1'b0);
        check_val("o_ar_ready", o_ar_ready, 1'b1);
        check_val("o_aw_ready", o_aw_ready, 1'b1);
        end_test("reset");

        begin_test();                           // Also fills every SRAM word
        for (int w = 0; w < DEPTH; w += 4) run_req(1'b1, w, 3'd5, '1);
        for (int w = 0; w < DEPTH; w += 4) run_req(1'b0, w, 3'd5, '0);
        end_test("round_trip");

        begin_test();
        for (int i = 0; i < 16; i++) begin
            size = 3'd3 + 3'($urandom % 2);
            word = pick_word(size, DEPTH);
            run_req(1'b1, word, size, '1);
            run_req(1'b0, word, size, '0);
        end
        end_test("narrow");

        begin_test();
        for (int i = 0; i < 16; i++) begin
            word = pick_word(3'd5, DEPTH);
            run_req(1'b1, word, 3'd5, $urandom);
            run_req(1'b0, word, 3'd5, '0);
        end
        end_test("strobes");

        begin_test();
        for (int i = 0; i < 8; i++) begin
            size = 3'd3 + 3'($urandom % 3);
            word = DEPTH + pick_word(size, 64);
            run_req(1'b1, word, size, '1);
            run_req(1'b0, word, size, '0);
        end
        end_test("out_of_range");

        begin_test();
        ready_pct = 25;                         // Heavier stalls on r and b
        for (int i = 0; i < 32; i++) begin
            size = 3'd3 + 3'($urandom % 3);
            run_req(1'($urandom), pick_word(size, DEPTH + 32), size, $urandom);
        end
        check_val("response count", n_rsp, n_req);
        end_test("backpressure");

        $display("summary: 6 tests, %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: testbench/tb_line_model.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Reference line memory model
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package tb_line_model;

    localparam int DEPTH = 256;                  // SRAM size in 64-bit words

    logic [63:0] words [DEPTH];

    // 1, 2 or 4 beats for sizes 3, 4 and 5
    function automatic int beats_of(input logic [2:0] size);
        return 1 << (int'(size) - 3);
    endfunction

    function automatic void apply_write(input line_bus_pkg::line_wreq_t w);
        int idx;
        for (int k = 0; k < beats_of(w.req.size); k++) begin
            idx = int'(w.req.addr >> 3) + k;
            if (idx < DEPTH) begin
                for (int b = 0; b < 8; b++) begin
                    if (w.strb[k*8 + b]) begin
                        words[idx][b*8 +: 8] = w.data[k*64 + b*8 +: 8];
                    end
                end
            end
        end
    endfunction

    // Stored beats in the low slices, zero above and for missing words
    function automatic line_bus_pkg::line_rsp_t expect_read(input line_bus_pkg::line_req_t r);
        line_bus_pkg::line_rsp_t rsp;
        int                      idx;
        rsp = '{data: '0, resp: line_bus_pkg::RESP_OKAY, id: r.id};
        for (int k = 0; k < beats_of(r.size); k++) begin
            idx = int'(r.addr >> 3) + k;
            if (idx < DEPTH) begin
                rsp.data[k*64 +: 64] = words[idx];
            end else begin
                rsp.resp = line_bus_pkg::RESP_SLVERR;
            end
        end
        return rsp;
    endfunction

    function automatic logic [1:0] expect_bresp(input line_bus_pkg::line_req_t r);
        if (int'(r.addr >> 3) + beats_of(r.size) > DEPTH) begin
            return line_bus_pkg::RESP_SLVERR;
        end
        return line_bus_pkg::RESP_OKAY;
    endfunction

endpackage

// File: src/line_mem_subsys.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Line memory subsystem
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module line_mem_subsys #(
    parameter int LINE_W     = line_bus_pkg::LINE_W,
    parameter int BUS_W      = line_bus_pkg::BUS_W,
    parameter int SRAM_DEPTH = 256,
    parameter int FIFO_DEPTH = 2
) (
    input  logic                      i_clk,
    input  logic                      i_nrst,
    input  logic                      i_ar_valid,
    input  line_bus_pkg::line_req_t   i_ar,
    output logic                      o_ar_ready,
    input  logic                      i_aw_valid,
    input  line_bus_pkg::line_wreq_t  i_aw,
    output logic                      o_aw_ready,
    output logic                      o_r_valid,
    output line_bus_pkg::line_rsp_t   o_r,
    input  logic                      i_r_ready,
    output logic                      o_b_valid,
    output line_bus_pkg::line_bresp_t o_b,
    input  logic                      i_b_ready
);

    logic                     ar_req_valid, ar_req_ready;
    logic                     aw_req_valid, aw_req_ready;
    line_bus_pkg::line_req_t  ar_req;
    line_bus_pkg::line_wreq_t aw_req;
    logic                     mem_ar_valid, mem_ar_ready;
    logic                     mem_aw_valid, mem_aw_ready;
    logic                     mem_w_valid, mem_w_ready;
    logic                     mem_r_valid, mem_r_ready;
    logic                     mem_b_valid, mem_b_ready;
    line_bus_pkg::mem_addr_t  mem_ar, mem_aw;
    line_bus_pkg::mem_w_t     mem_w;
    line_bus_pkg::mem_r_t     mem_r;
    line_bus_pkg::mem_b_t     mem_b;

    req_fifo #(.T(line_bus_pkg::line_req_t), .DEPTH(FIFO_DEPTH)) ar_fifo (
        .i_clk, .i_nrst,
        .i_valid(i_ar_valid), .i_data(i_ar), .o_ready(o_ar_ready),
        .o_valid(ar_req_valid), .o_data(ar_req), .i_ready(ar_req_ready)
    );

    req_fifo #(.T(line_bus_pkg::line_wreq_t), .DEPTH(FIFO_DEPTH)) aw_fifo (
        .i_clk, .i_nrst,
        .i_valid(i_aw_valid), .i_data(i_aw), .o_ready(o_aw_ready),
        .o_valid(aw_req_valid), .o_data(aw_req), .i_ready(aw_req_ready)
    );

    line_serdes #(.LINE_W(LINE_W), .BUS_W(BUS_W)) u_serdes (
        .i_clk, .i_nrst,
        .i_ar_valid(ar_req_valid), .i_ar(ar_req), .o_ar_ready(ar_req_ready),
        .i_aw_valid(aw_req_valid), .i_aw(aw_req), .o_aw_ready(aw_req_ready),
        .o_r_valid, .o_r, .i_r_ready,
        .o_b_valid, .o_b, .i_b_ready,
        .o_mem_ar_valid(mem_ar_valid), .o_mem_ar(mem_ar), .i_mem_ar_ready(mem_ar_ready),
        .o_mem_aw_valid(mem_aw_valid), .o_mem_aw(mem_aw), .i_mem_aw_ready(mem_aw_ready),
        .o_mem_w_valid(mem_w_valid), .o_mem_w(mem_w), .i_mem_w_ready(mem_w_ready),
        .i_mem_r_valid(mem_r_valid), .i_mem_r(mem_r), .o_mem_r_ready(mem_r_ready),
        .i_mem_b_valid(mem_b_valid), .i_mem_b(mem_b), .o_mem_b_ready(mem_b_ready)
    );

    burst_sram #(
        .BUS_W(BUS_W), .SRAM_DEPTH(SRAM_DEPTH), .ADDR_W(line_bus_pkg::ADDR_W)
    ) u_sram (
        .i_clk, .i_nrst,
        .i_ar_valid(mem_ar_valid), .i_ar(mem_ar), .o_ar_ready(mem_ar_ready),
        .i_aw_valid(mem_aw_valid), .i_aw(mem_aw), .o_aw_ready(mem_aw_ready),
        .i_w_valid(mem_w_valid), .i_w(mem_w), .o_w_ready(mem_w_ready),
        .o_r_valid(mem_r_valid), .o_r(mem_r), .i_r_ready(mem_r_ready),
        .o_b_valid(mem_b_valid), .o_b(mem_b), .i_b_ready(mem_b_ready)
    );

endmodule

// File: src/burst_sram.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Burst SRAM
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module burst_sram #(
    parameter int BUS_W      = line_bus_pkg::BUS_W,
    parameter int SRAM_DEPTH = 256,
    parameter int ADDR_W     = line_bus_pkg::ADDR_W
) (
    input  logic                    i_clk,
    input  logic                    i_nrst,
    input  logic                    i_ar_valid,
    input  line_bus_pkg::mem_addr_t i_ar,
    output logic                    o_ar_ready,
    input  logic                    i_aw_valid,
    input  line_bus_pkg::mem_addr_t i_aw,
    output logic                    o_aw_ready,
    input  logic                    i_w_valid,
    input  line_bus_pkg::mem_w_t    i_w,
    output logic                    o_w_ready,
    output logic                    o_r_valid,
    output line_bus_pkg::mem_r_t    o_r,
    input  logic                    i_r_ready,
    output logic                    o_b_valid,
    output line_bus_pkg::mem_b_t    o_b,
    input  logic                    i_b_ready
);

    localparam int OFF_W   = $clog2(BUS_W / 8);
    localparam int WADDR_W = ADDR_W - OFF_W;
    localparam int IDX_W   = $clog2(SRAM_DEPTH);

    typedef enum logic [1:0] {ST_IDLE, ST_READ, ST_WRITE, ST_RESP} state_t;

    state_t                        state;
    logic [BUS_W-1:0]              mem [SRAM_DEPTH];
    logic [WADDR_W-1:0]            waddr;
    logic [WADDR_W-1:0]            waddr_nxt;
    logic [7:0]                    cnt;
    logic [line_bus_pkg::ID_W-1:0] id;
    logic                          err;         // Sticky over the burst
    logic                          beat_err;
    logic [BUS_W-1:0]              rdata;
    logic                          ar_go;
    logic                          aw_go;
    logic                          r_beat;
    logic                          w_beat;

    assign o_ar_ready = (state == ST_IDLE);
    assign o_aw_ready = (state == ST_IDLE) && !i_ar_valid;
    assign o_w_ready  = (state == ST_WRITE);
    assign o_r_valid  = (state == ST_READ);
    assign o_b_valid  = (state == ST_RESP);

    assign ar_go    = i_ar_valid && o_ar_ready;
    assign aw_go    = i_aw_valid && o_aw_ready;
    assign r_beat   = o_r_valid && i_r_ready;
    assign w_beat   = i_w_valid && o_w_ready;
    assign beat_err = (waddr >= SRAM_DEPTH);

    // Word that the next read beat will present
    assign waddr_nxt = ar_go ? i_ar.addr[ADDR_W-1:OFF_W] : waddr + 1'b1;

    assign o_r = '{data: rdata,
                   resp: (err || beat_err) ? line_bus_pkg::RESP_SLVERR : line_bus_pkg::RESP_OKAY,
                   last: (cnt == '0),
                   id:   id};
    assign o_b = '{resp: err ? line_bus_pkg::RESP_SLVERR : line_bus_pkg::RESP_OKAY, id: id};

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            state <= ST_IDLE;
            waddr <= '0;
            cnt   <= '0;
            id    <= '0;
            err   <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    err <= 1'b0;
                    if (ar_go) begin
                        state <= ST_READ;
                        waddr <= i_ar.addr[ADDR_W-1:OFF_W];
                        cnt   <= i_ar.len;
                        id    <= i_ar.id;
                    end else if (aw_go) begin
                        state <= ST_WRITE;
                        waddr <= i_aw.addr[ADDR_W-1:OFF_W];
                        cnt   <= i_aw.len;
                        id    <= i_aw.id;
                    end
                end
                ST_READ, ST_WRITE: begin
                    if (r_beat || w_beat) begin
                        err   <= err || beat_err;
                        waddr <= waddr + 1'b1;
                        cnt   <= cnt - 1'b1;
                        if (cnt == '0) begin
                            state <= (state == ST_READ) ? ST_IDLE : ST_RESP;
                        end
                    end
                end
                ST_RESP: begin
                    if (i_b_ready) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Storage and read port
    always_ff @(posedge i_clk) begin
        if (ar_go || r_beat) begin
            rdata <= (waddr_nxt < SRAM_DEPTH) ? mem[waddr_nxt[IDX_W-1:0]] : '0;
        end
        if (w_beat && !beat_err) begin
            for (int b = 0; b < BUS_W / 8; b++) begin
                if (i_w.strb[b]) begin
                    mem[waddr[IDX_W-1:0]][b*8 +: 8] <= i_w.data[b*8 +: 8];
                end
            end
        end
    end

endmodule

// File: src/line_serdes.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Line to burst serializer
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module line_serdes #(
    parameter int LINE_W = line_bus_pkg::LINE_W,
    parameter int BUS_W  = line_bus_pkg::BUS_W
) (
    input  logic                      i_clk,
    input  logic                      i_nrst,
    input  logic                      i_ar_valid,
    input  line_bus_pkg::line_req_t   i_ar,
    output logic                      o_ar_ready,
    input  logic                      i_aw_valid,
    input  line_bus_pkg::line_wreq_t  i_aw,
    output logic                      o_aw_ready,
    output logic                      o_r_valid,
    output line_bus_pkg::line_rsp_t   o_r,
    input  logic                      i_r_ready,
    output logic                      o_b_valid,
    output line_bus_pkg::line_bresp_t o_b,
    input  logic                      i_b_ready,
    output logic                      o_mem_ar_valid,
    output line_bus_pkg::mem_addr_t   o_mem_ar,
    input  logic                      i_mem_ar_ready,
    output logic                      o_mem_aw_valid,
    output line_bus_pkg::mem_addr_t   o_mem_aw,
    input  logic                      i_mem_aw_ready,
    output logic                      o_mem_w_valid,
    output line_bus_pkg::mem_w_t      o_mem_w,
    input  logic                      i_mem_w_ready,
    input  logic                      i_mem_r_valid,
    input  line_bus_pkg::mem_r_t      i_mem_r,
    output logic                      o_mem_r_ready,
    input  logic                      i_mem_b_valid,
    input  line_bus_pkg::mem_b_t      i_mem_b,
    output logic                      o_mem_b_ready
);

    localparam int BEATS   = LINE_W / BUS_W;
    localparam int CNT_W   = $clog2(BEATS);
    localparam int LSTRB_W = LINE_W / 8;
    localparam int BSTRB_W = BUS_W / 8;

    typedef enum logic [1:0] {ST_IDLE, ST_READ, ST_WRITE} state_t;

    state_t                  state;
    logic [BEATS-1:0]        rmux;          // One-hot slice for the next read beat
    logic [CNT_W-1:0]        req_len;       // Beats left after the current one
    logic                    b_wait;
    logic [LINE_W-1:0]       line_q;
    logic [LSTRB_W-1:0]      strb_q;
    logic [LINE_W-1:0]       line_gather;
    line_bus_pkg::line_req_t req_sel;
    line_bus_pkg::mem_addr_t mem_req;
    logic                    accept;
    logic                    ar_go;
    logic                    aw_go;
    logic                    r_beat;
    logic                    w_beat;
    logic                    last_beat;

    // Read has priority, and nothing new starts while a write response is owed
    assign accept  = (state == ST_IDLE) && !b_wait;
    assign req_sel = i_ar_valid ? i_ar : i_aw.req;

    assign mem_req = '{addr:  req_sel.addr,
                       len:   line_bus_pkg::size_to_len(req_sel.size),
                       size:  line_bus_pkg::size_to_beat(req_sel.size),
                       burst: line_bus_pkg::BURST_INCR,
                       id:    req_sel.id};

    assign o_mem_ar_valid = accept && i_ar_valid;
    assign o_mem_aw_valid = accept && !i_ar_valid && i_aw_valid;
    assign o_mem_ar       = mem_req;
    assign o_mem_aw       = mem_req;
    assign o_ar_ready     = accept && i_mem_ar_ready;            // Pop with the address
    assign o_aw_ready     = accept && !i_ar_valid && i_mem_aw_ready;
    assign ar_go          = o_mem_ar_valid && i_mem_ar_ready;
    assign aw_go          = o_mem_aw_valid && i_mem_aw_ready;
    assign last_beat      = (req_len == '0);

    // Current read beat merged into its slice
    always_comb begin
        line_gather = line_q;
        for (int k = 0; k < BEATS; k++) begin
            if (rmux[k]) begin
                line_gather[k*BUS_W +: BUS_W] = i_mem_r.data;
            end
        end
    end

    assign o_mem_r_ready = i_r_ready;
    assign r_beat        = (state == ST_READ) && i_mem_r_valid && i_r_ready;
    assign o_r_valid     = (state == ST_READ) && i_mem_r_valid && last_beat;
    assign o_r           = '{data: line_gather, resp: i_mem_r.resp, id: i_mem_r.id};

    assign o_mem_w_valid = (state == ST_WRITE);
    assign o_mem_w       = '{data: line_q[BUS_W-1:0], strb: strb_q[BSTRB_W-1:0], last: last_beat};
    assign w_beat        = o_mem_w_valid && i_mem_w_ready;

    assign o_mem_b_ready = i_b_ready;
    assign o_b_valid     = b_wait && i_mem_b_valid;
    assign o_b           = '{resp: i_mem_b.resp, id: i_mem_b.id};

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            state   <= ST_IDLE;
            rmux    <= '0;
            req_len <= '0;
            b_wait  <= 1'b0;
        end else begin
            if (o_b_valid && i_b_ready) begin
                b_wait <= 1'b0;
            end
            case (state)
                ST_IDLE: begin
                    if (ar_go) begin
                        state   <= ST_READ;
                        rmux    <= BEATS'(1);
                        req_len <= mem_req.len[CNT_W-1:0];
                    end else if (aw_go) begin
                        state   <= ST_WRITE;
                        req_len <= mem_req.len[CNT_W-1:0];
                    end
                end
                ST_READ: begin
                    if (r_beat) begin
                        rmux <= {rmux[BEATS-2:0], 1'b0};
                        if (last_beat) begin
                            state <= ST_IDLE;
                        end else begin
                            req_len <= req_len - 1'b1;
                        end
                    end
                end
                ST_WRITE: begin
                    if (w_beat) begin
                        if (last_beat) begin
                            state  <= ST_IDLE;
                            b_wait <= 1'b1;        // Hold off until the B beat
                        end else begin
                            req_len <= req_len - 1'b1;
                        end
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (ar_go) begin
            line_q <= '0;
        end else if (aw_go) begin
            line_q <= i_aw.data;
            strb_q <= i_aw.strb;
        end else if (r_beat) begin
            line_q <= line_gather;
        end else if (w_beat) begin
            line_q <= line_q >> BUS_W;     // Next beat into the low slice
            strb_q <= strb_q >> BSTRB_W;
        end
    end

endmodule

// File: src/req_fifo.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Request FIFO
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module req_fifo #(
    parameter type T     = logic [7:0],
    parameter int  DEPTH = 2
) (
    input  logic i_clk,
    input  logic i_nrst,
    input  logic i_valid,
    input  T     i_data,
    output logic o_ready,
    output logic o_valid,
    output T     o_data,
    input  logic i_ready
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    T                 mem [DEPTH];
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [CNT_W-1:0] count;
    logic             push;
    logic             pop;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign o_ready = (count != CNT_W'(DEPTH));     // Full is the only stall
    assign o_valid = (count != '0);
    assign o_data  = mem[rd_ptr];
    assign push    = i_valid && o_ready;
    assign pop     = o_valid && i_ready;

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (push) begin
            mem[wr_ptr] <= i_data;
        end
    end

endmodule

// File: src/line_bus_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Line and memory bus types
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package line_bus_pkg;

    localparam int ADDR_W = 32;
    localparam int BUS_W  = 64;
    localparam int LINE_W = 256;
    localparam int BEATS  = LINE_W / BUS_W;
    localparam int ID_W   = 4;

    localparam logic [1:0] RESP_OKAY   = 2'd0;
    localparam logic [1:0] RESP_SLVERR = 2'd2;
    localparam logic [1:0] BURST_INCR  = 2'd1;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [2:0]        size;            // log2 of request bytes
        logic [ID_W-1:0]   id;
    } line_req_t;

    typedef struct packed {
        line_req_t           req;
        logic [LINE_W-1:0]   data;
        logic [LINE_W/8-1:0] strb;
    } line_wreq_t;

    typedef struct packed {
        logic [LINE_W-1:0] data;
        logic [1:0]        resp;
        logic [ID_W-1:0]   id;
    } line_rsp_t;

    typedef struct packed {
        logic [1:0]      resp;
        logic [ID_W-1:0] id;
    } line_bresp_t;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [7:0]        len;             // Beats minus one
        logic [2:0]        size;
        logic [1:0]        burst;
        logic [ID_W-1:0]   id;
    } mem_addr_t;

    typedef struct packed {
        logic [BUS_W-1:0]   data;
        logic [BUS_W/8-1:0] strb;
        logic               last;
    } mem_w_t;

    typedef struct packed {
        logic [BUS_W-1:0] data;
        logic [1:0]       resp;
        logic             last;
        logic [ID_W-1:0]  id;
    } mem_r_t;

    typedef struct packed {
        logic [1:0]      resp;
        logic [ID_W-1:0] id;
    } mem_b_t;

    // Burst length for a line size code
    function automatic logic [7:0] size_to_len(input logic [2:0] size);
        case (size)
            3'd4:    return 8'd1;           // 16 bytes
            3'd5:    return 8'd3;           // 32 bytes
            default: return 8'd0;
        endcase
    endfunction

    // Beat size never wider than the 8-byte bus
    function automatic logic [2:0] size_to_beat(input logic [2:0] size);
        return (size >= 3'd3) ? 3'd3 : size;
    endfunction

endpackage
